// ==== Makefile ====
TOP = tb_egr_tqu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --timescale 1ns/10ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir

# pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+test
hdl/egr_tqu_pkg.sv
hdl/pkt_buf_ram.sv
hdl/tqu_rrsp_rcv.sv
hdl/tqu_queue_ctrl.sv
hdl/tqu.sv
hdl/egr_tqu_top.sv
test/tb_egr_tqu.sv

// ==== hdl/egr_tqu_pkg.sv ====
package egr_tqu_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // one packet buffer word
    localparam int DATA_WORD_W   = 64;
    // words per bank, one circular queue each
    localparam int PKT_BUF_DEPTH = 16;
    // bank address bits
    localparam int PKT_BUF_AW    = 4;
    // opaque tag sent back with every read response
    localparam int PKT_TAG_W     = 7;

    //////////////////////////////////////////////////
    // words and addresses
    //////////////////////////////////////////////////

    typedef logic [DATA_WORD_W-1:0] data_word_t;
    typedef logic [PKT_BUF_AW-1:0]  pkt_buf_addr_t;

    // selects control bank or data bank
    typedef enum logic {
        WORD_TYPE_CTRL = 1'b0,
        WORD_TYPE_DATA = 1'b1
    } word_type_e;

    //////////////////////////////////////////////////
    // read response side
    //////////////////////////////////////////////////

    // response tag, only word_type steers the word
    typedef struct packed {
        word_type_e             word_type;
        logic [PKT_TAG_W-1:0]   pkt_tag;
    } rrsp_id_t;

    // one response beat from packet memory
    typedef struct packed {
        logic       valid;
        rrsp_id_t   id;
        data_word_t word;
    } rrsp_t;

    //////////////////////////////////////////////////
    // transmit controller and bank side
    //////////////////////////////////////////////////

    // word handed out on a pull
    typedef struct packed {
        logic       valid;
        data_word_t word;
    } tq_word_t;

    // request into one single-port bank
    typedef struct packed {
        pkt_buf_addr_t addr;
        logic          rd_en;
        logic          wr_en;
        data_word_t    wdata;
    } buf_port_t;

endpackage : egr_tqu_pkg

// ==== hdl/egr_tqu_top.sv ====
`timescale 1ns/10ps

module egr_tqu_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // read responses from packet memory
    input  egr_tqu_pkg::rrsp_t    rrsp,
    output logic                  rrsp_stall,
    // transmit controller
    input  logic                  ctrl_pull,
    input  logic                  data_pull,
    output logic                  ctrl_ready,
    output logic                  data_ready,
    output egr_tqu_pkg::tq_word_t ctrl_out,
    output egr_tqu_pkg::tq_word_t data_out
);
    import egr_tqu_pkg::*;

    // bank requests and read words
    buf_port_t  ctrl_port;
    buf_port_t  data_port;
    data_word_t ctrl_rdata;
    data_word_t data_rdata;

    //////////////////////////////////////////////////
    // queuing unit
    //////////////////////////////////////////////////

    tqu tqu0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rrsp       (rrsp),
        .rrsp_stall (rrsp_stall),
        .ctrl_pull  (ctrl_pull),
        .data_pull  (data_pull),
        .ctrl_ready (ctrl_ready),
        .data_ready (data_ready),
        .ctrl_out   (ctrl_out),
        .data_out   (data_out),
        .ctrl_port  (ctrl_port),
        .ctrl_rdata (ctrl_rdata),
        .data_port  (data_port),
        .data_rdata (data_rdata)
    );

    //////////////////////////////////////////////////
    // packet buffer banks
    //////////////////////////////////////////////////

    // control words
    pkt_buf_ram ctrl_bank (
        .clk   (clk),
        .port  (ctrl_port),
        .rdata (ctrl_rdata)
    );

    // data words
    pkt_buf_ram data_bank (
        .clk   (clk),
        .port  (data_port),
        .rdata (data_rdata)
    );

endmodule : egr_tqu_top

// ==== hdl/pkt_buf_ram.sv ====
`timescale 1ns/10ps

module pkt_buf_ram (
    input  logic                    clk,
    // address, strobes and write word
    input  egr_tqu_pkg::buf_port_t  port,
    // read word, one edge after rd_en
    output egr_tqu_pkg::data_word_t rdata
);
    import egr_tqu_pkg::*;

    // storage array
    data_word_t mem [PKT_BUF_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.addr] <= port.wdata;
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            rdata <= mem[port.addr];
        end
    end

endmodule : pkt_buf_ram

// ==== hdl/tqu.sv ====
`timescale 1ns/10ps

module tqu (
    input  logic                    clk,
    input  logic                    rst_n,
    // read response stream
    input  egr_tqu_pkg::rrsp_t      rrsp,
    output logic                    rrsp_stall,
    // transmit controller pulls
    input  logic                    ctrl_pull,
    input  logic                    data_pull,
    output logic                    ctrl_ready,
    output logic                    data_ready,
    output egr_tqu_pkg::tq_word_t   ctrl_out,
    output egr_tqu_pkg::tq_word_t   data_out,
    // control bank
    output egr_tqu_pkg::buf_port_t  ctrl_port,
    input  egr_tqu_pkg::data_word_t ctrl_rdata,
    // data bank
    output egr_tqu_pkg::buf_port_t  data_port,
    input  egr_tqu_pkg::data_word_t data_rdata
);
    import egr_tqu_pkg::*;

    // word waiting in the receiver
    data_word_t held_word;
    // per-queue write handshake
    logic       ctrl_wr_req;
    logic       ctrl_wr_ack;
    logic       data_wr_req;
    logic       data_wr_ack;

    //////////////////////////////////////////////////
    // response receiver
    //////////////////////////////////////////////////

    tqu_rrsp_rcv rrsp_rcv (
        .clk         (clk),
        .rst_n       (rst_n),
        .rrsp        (rrsp),
        .rrsp_stall  (rrsp_stall),
        .held_word   (held_word),
        .ctrl_wr_req (ctrl_wr_req),
        .data_wr_req (data_wr_req),
        .ctrl_wr_ack (ctrl_wr_ack),
        .data_wr_ack (data_wr_ack)
    );

    //////////////////////////////////////////////////
    // queues
    //////////////////////////////////////////////////

    // metadata words
    tqu_queue_ctrl ctrl_q (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (ctrl_wr_req),
        .wr_data  (held_word),
        .wr_ack   (ctrl_wr_ack),
        .pull     (ctrl_pull),
        .ready    (ctrl_ready),
        .word_out (ctrl_out),
        .port     (ctrl_port),
        .rdata    (ctrl_rdata)
    );

    // packet data words
    tqu_queue_ctrl data_q (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (data_wr_req),
        .wr_data  (held_word),
        .wr_ack   (data_wr_ack),
        .pull     (data_pull),
        .ready    (data_ready),
        .word_out (data_out),
        .port     (data_port),
        .rdata    (data_rdata)
    );

endmodule : tqu

// ==== hdl/tqu_queue_ctrl.sv ====
`timescale 1ns/10ps

module tqu_queue_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    // write side from the receiver
    input  logic                    wr_req,
    input  egr_tqu_pkg::data_word_t wr_data,
    output logic                    wr_ack,
    // pull side toward the transmit controller
    input  logic                    pull,
    output logic                    ready,
    output egr_tqu_pkg::tq_word_t   word_out,
    // single bank port
    output egr_tqu_pkg::buf_port_t  port,
    input  egr_tqu_pkg::data_word_t rdata
);
    import egr_tqu_pkg::*;

    // address plus wrap bit
    typedef logic [PKT_BUF_AW:0] q_ptr_t;

    // one-hot pull machine
    typedef enum logic [2:0] {
        Q_IDLE  = 3'b001,
        Q_READY = 3'b010,
        Q_PULL  = 3'b100
    } q_state_e;

    q_ptr_t   wr_ptr;
    q_ptr_t   rd_ptr;
    q_ptr_t   q_count;
    logic     q_empty;
    logic     q_full;
    logic     rd_en;
    q_state_e state;
    q_state_e state_nxt;

    //////////////////////////////////////////////////
    // queue pointers
    //////////////////////////////////////////////////

    // same wrap and same slot
    assign q_empty = (wr_ptr == rd_ptr);
    // other wrap and same slot
    assign q_full  = (wr_ptr[PKT_BUF_AW] != rd_ptr[PKT_BUF_AW]) &&
                     (wr_ptr[PKT_BUF_AW-1:0] == rd_ptr[PKT_BUF_AW-1:0]);
    // words stored modulo pointer width
    assign q_count = wr_ptr - rd_ptr;

    // bank read in READY on a pull
    assign rd_en  = (state == Q_READY) & pull;
    // read owns the port and the write waits
    assign wr_ack = wr_req & ~q_full & ~rd_en;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ack) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // pull state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= Q_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            // wait for a stored word
            Q_IDLE: begin
                if (!q_empty) begin
                    state_nxt = Q_READY;
                end
            end
            // offer it until pulled
            Q_READY: begin
                if (pull) begin
                    state_nxt = Q_PULL;
                end
            end
            // bank data valid this cycle
            Q_PULL: begin
                state_nxt = Q_IDLE;
            end
            default: begin
                state_nxt = Q_IDLE;
            end
        endcase
    end

    assign ready = (state == Q_READY);

    // one-cycle word and zero otherwise
    assign word_out.valid = (state == Q_PULL);
    assign word_out.word  = (state == Q_PULL) ? rdata : '0;

    //////////////////////////////////////////////////
    // bank port
    //////////////////////////////////////////////////

    assign port.addr  = rd_en ? rd_ptr[PKT_BUF_AW-1:0] : wr_ptr[PKT_BUF_AW-1:0];
    assign port.rd_en = rd_en;
    assign port.wr_en = wr_ack;
    assign port.wdata = wr_data;

    // the bank is read only with a word stored
    a_rd_stored : assert property (@(posedge clk) disable iff (!rst_n)
        port.rd_en |-> !q_empty)
        else $error("bank read from an empty queue");

    // occupancy never passes the bank size
    a_no_overrun : assert property (@(posedge clk) disable iff (!rst_n)
        q_count <= q_ptr_t'(PKT_BUF_DEPTH))
        else $error("queue written while full");

endmodule : tqu_queue_ctrl

// ==== hdl/tqu_rrsp_rcv.sv ====
`timescale 1ns/10ps

module tqu_rrsp_rcv (
    input  logic                    clk,
    input  logic                    rst_n,
    // response stream from packet memory
    input  egr_tqu_pkg::rrsp_t      rrsp,
    output logic                    rrsp_stall,
    // write side toward both queues
    output egr_tqu_pkg::data_word_t held_word,
    output logic                    ctrl_wr_req,
    output logic                    data_wr_req,
    input  logic                    ctrl_wr_ack,
    input  logic                    data_wr_ack
);
    import egr_tqu_pkg::*;

    // holding register state
    logic       held_vld;
    word_type_e held_type;
    // queue took the held word this cycle
    logic       held_ack;
    // new response enters the holding register
    logic       held_load;

    //////////////////////////////////////////////////
    // accept / stall
    //////////////////////////////////////////////////

    // ack from the requested queue frees the word
    assign held_ack   = ctrl_wr_ack | data_wr_ack;

    // blocked while occupied and not drained now
    assign rrsp_stall = held_vld & ~held_ack;

    // register frees and reloads in the same cycle
    assign held_load  = rrsp.valid & ~rrsp_stall;

    //////////////////////////////////////////////////
    // holding register
    //////////////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            held_vld  <= 1'b0;
            held_type <= WORD_TYPE_CTRL;
        end else begin
            if (held_load) begin
                held_vld  <= 1'b1;
                held_type <= rrsp.id.word_type;
            end else if (held_ack) begin
                held_vld  <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (held_load) begin
            held_word <= rrsp.word;
        end
    end

    // steer by word type
    assign ctrl_wr_req = held_vld & (held_type == WORD_TYPE_CTRL);
    assign data_wr_req = held_vld & (held_type == WORD_TYPE_DATA);

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // a held word leaves only on the ack of its own queue
    a_held_kept : assert property (@(posedge clk) disable iff (!rst_n)
        held_vld && !((held_type == WORD_TYPE_CTRL) ? ctrl_wr_ack : data_wr_ack)
        |=> held_vld && $stable(held_word) && $stable(held_type))
        else $error("held word replaced while its queue had not taken it");

    // requests and acks never touch both banks at once
    a_one_bank : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl_wr_req | ctrl_wr_ack, data_wr_req | data_wr_ack}))
        else $error("control and data write active together");

endmodule : tqu_rrsp_rcv

// ==== test/tb_egr_tqu_ref.svh ====
`ifndef TB_EGR_TQU_REF_SVH
`define TB_EGR_TQU_REF_SVH

//////////////////////////////////////////////////
// reference queues
//////////////////////////////////////////////////

// words accepted but not yet delivered, in acceptance order
data_word_t ref_ctrl_q[$];
data_word_t ref_data_q[$];

// an accepted response joins the queue of its type
function automatic void ref_push(input word_type_e t, input data_word_t w);
    if (t == WORD_TYPE_CTRL) begin
        ref_ctrl_q.push_back(w);
    end else begin
        ref_data_q.push_back(w);
    end
endfunction

function automatic int ref_size(input word_type_e t);
    return (t == WORD_TYPE_CTRL) ? ref_ctrl_q.size() : ref_data_q.size();
endfunction

// next word expected on the output of that type, removed from the model
function automatic data_word_t ref_next(input word_type_e t);
    if (t == WORD_TYPE_CTRL) begin
        return ref_ctrl_q.pop_front();
    end
    return ref_data_q.pop_front();
endfunction

//////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////

// pull mode 0 off, 1 held high, 2 random level
function automatic logic pull_level(input logic [1:0] mode);
    case (mode)
        2'd0: return 1'b0;
        2'd1: return 1'b1;
        default: return 1'($urandom_range(0, 1));
    endcase
endfunction

// one response, held until the receiver takes it
task automatic send_word(input word_type_e t);
    rrsp.valid        = 1'b1;
    rrsp.id.word_type = t;
    rrsp.id.pkt_tag   = 7'($urandom);
    // sequence number on top eases debug
    rrsp.word         = {16'(sent_cnt), 16'($urandom), $urandom};
    sent_cnt++;
    do begin
        @(posedge clk);
    end while (rrsp_stall);
    @(negedge clk);
    rrsp.valid = 1'b0;
endtask

// pull both queues until the model holds nothing
task automatic wait_drain();
    ctrl_mode <= 2'd1;
    data_mode <= 2'd1;
    while (ref_size(WORD_TYPE_CTRL) != 0 || ref_size(WORD_TYPE_DATA) != 0) begin
        @(negedge clk);
    end
    // room for a stray extra word to show up
    repeat (6) @(negedge clk);
endtask

`endif

// ==== test/tb_egr_tqu.sv ====
`timescale 1ns/10ps

module tb_egr_tqu;
    import egr_tqu_pkg::*;

    localparam int CLK_PERIOD      = 40;
    // words sent over all five phases
    localparam int TOTAL_WORDS     = 12 + 24 + 20 + 400;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 12 + 200;

    logic       clk;
    logic       rst_n;
    rrsp_t      rrsp;
    logic       rrsp_stall;
    logic       ctrl_pull = 1'b0;
    logic       data_pull = 1'b0;
    logic       ctrl_ready;
    logic       data_ready;
    tq_word_t   ctrl_out;
    tq_word_t   data_out;

    // pull behaviour per queue
    logic [1:0] ctrl_mode = 2'd0;
    logic [1:0] data_mode = 2'd0;
    // pull seen with ready high at the last edge
    logic       ctrl_taken;
    logic       data_taken;
    int         val_errs;
    int         proto_errs;
    int         sent_cnt;

    `include "tb_egr_tqu_ref.svh"

    egr_tqu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rrsp       (rrsp),
        .rrsp_stall (rrsp_stall),
        .ctrl_pull  (ctrl_pull),
        .data_pull  (data_pull),
        .ctrl_ready (ctrl_ready),
        .data_ready (data_ready),
        .ctrl_out   (ctrl_out),
        .data_out   (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // pull levels change on the falling edge only
    always @(negedge clk) begin
        ctrl_pull = pull_level(ctrl_mode);
        data_pull = pull_level(data_mode);
    end

    //////////////////////////////////////////////////
    // compare
    //////////////////////////////////////////////////

    task automatic check_stream(input word_type_e t, input tq_word_t out,
                                input logic taken, input logic rdy);
        data_word_t exp;
        string      name;
        name = (t == WORD_TYPE_CTRL) ? "ctrl_out" : "data_out";
        // valid exactly one cycle after a taken pull
        assert (out.valid == taken) else begin
            proto_errs++;
            $display("%s valid is %0b at %0t but a pull taken one cycle before is %0b",
                     name, out.valid, $time, taken);
        end
        assert (!(out.valid && rdy)) else begin
            proto_errs++;
            $display("%s ready high while its word is valid at %0t", name, $time);
        end
        if (out.valid) begin
            assert (ref_size(t) > 0) else begin
                proto_errs++;
                $display("%s delivered a word at %0t with none left to deliver", name, $time);
            end
            if (ref_size(t) > 0) begin
                exp = ref_next(t);
                assert (out.word == exp) else begin
                    val_errs++;
                    $display("Fail %0t %s word %h, expected %h", $time, name, out.word, exp);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            ctrl_taken = 1'b0;
            data_taken = 1'b0;
        end else begin
            check_stream(WORD_TYPE_CTRL, ctrl_out, ctrl_taken, ctrl_ready);
            check_stream(WORD_TYPE_DATA, data_out, data_taken, data_ready);
            ctrl_taken = ctrl_pull & ctrl_ready;
            data_taken = data_pull & data_ready;
            // accepted response goes into the model
            if (rrsp.valid && !rrsp_stall) begin
                ref_push(rrsp.id.word_type, rrsp.word);
            end
        end
    end

    task automatic print_counts();
        $display("errors: %0d wrong value, %0d protocol, %0d words sent",
                 val_errs, proto_errs, sent_cnt);
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run stopped by the watchdog, words no longer delivered");
        print_counts();
        $display("Something failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h7325_e3a6));
        rst_n      = 1'b0;
        rrsp       = '0;
        val_errs   = 0;
        proto_errs = 0;
        sent_cnt   = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle outputs and pulls with ready low
        assert (!ctrl_ready && !data_ready && !ctrl_out.valid && !data_out.valid
                && !rrsp_stall) else begin
            proto_errs++;
            $display("outputs not idle after reset at %0t", $time);
        end
        ctrl_mode <= 2'd1;
        data_mode <= 2'd1;
        repeat (5) @(negedge clk);

        // control words only and pulled at once
        ctrl_mode <= 2'd1;
        data_mode <= 2'd0;
        for (int i = 0; i < 12; i++) begin
            send_word(WORD_TYPE_CTRL);
        end
        wait_drain();

        // interleaved types
        for (int i = 0; i < 24; i++) begin
            send_word((i % 3 == 0) ? WORD_TYPE_CTRL : WORD_TYPE_DATA);
        end
        wait_drain();

        // fill the control queue with no pulls
        ctrl_mode <= 2'd0;
        data_mode <= 2'd0;
        for (int i = 0; i < 17; i++) begin
            send_word(WORD_TYPE_CTRL);
        end
        // 16 stored plus one held
        repeat (10) begin
            assert (rrsp_stall) else begin
                proto_errs++;
                $display("rrsp_stall low at %0t with the control queue full", $time);
            end
            @(negedge clk);
        end
        ctrl_mode <= 2'd1;
        for (int i = 0; i < 3; i++) begin
            send_word(WORD_TYPE_CTRL);
        end
        wait_drain();

        // random gaps, types and pulls
        ctrl_mode <= 2'd2;
        data_mode <= 2'd2;
        for (int i = 0; i < 400; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) @(negedge clk);
            end
            send_word(word_type_e'($urandom_range(0, 1)));
        end
        wait_drain();

        // drained DUT offers nothing and holds nothing
        assert (!ctrl_ready && !data_ready && !ctrl_out.valid && !data_out.valid
                && !rrsp_stall) else begin
            proto_errs++;
            $display("queues not empty at the end of the run");
        end

        print_counts();
        if (val_errs + proto_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_egr_tqu
